/* bench/ppu_stimulus.txt */
# cmd operand expected, hex. W reg data, R reg expected (100 = not checked)
# V vram_addr data, P vram_const colour, B unused nmi
B 0 0
R 2 80
R 2 00
W 0 80
B 0 1
R 2 80
W 0 00
W 6 21
W 6 08
W 7 11
W 7 22
W 7 33
V 2108 11
V 2109 22
V 210A 33
W 0 04
W 6 21
W 6 08
W 7 44
W 7 55
W 7 66
V 2108 44
V 2128 55
V 2148 66
W 0 00
W 6 22
W 6 00
R 7 100
R 7 5A
W 6 3F
W 6 05
W 7 2A
W 6 3F
W 6 05
R 7 2A
W 6 3F
W 6 00
W 7 0F
W 6 3F
W 6 04
W 7 30
W 6 3F
W 6 04
R 7 0F
W 6 3F
W 6 0F
W 7 27
W 5 00
W 5 00
W 1 0A
P FF 27
P 00 0F
W 1 0B
P FF 20
W 1 00

/* flist.f */
+incdir+rtl
rtl/ppu_pkg.sv
rtl/ppu_raster_timer.sv
rtl/ppu_scroll_regs.sv
rtl/ppu_bg_fetch.sv
rtl/ppu_palette_ram.sv
rtl/ppu_bus_regs.sv
rtl/ppu_top.sv
bench/tb_ppu.sv

/* Bender.yml */
package:
  name: ppu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ppu_pkg.sv
      - rtl/ppu_raster_timer.sv
      - rtl/ppu_scroll_regs.sv
      - rtl/ppu_bg_fetch.sv
      - rtl/ppu_palette_ram.sv
      - rtl/ppu_bus_regs.sv
      - rtl/ppu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_ppu.sv

/* bench/tb_ppu.sv */
// Testbench for the background picture processor
// Reads bus and raster commands from a stimulus file, checks VRAM, status, NMI and colours
`timescale 1ns/1ps
`include "ppu_settings.svh"

module tb_ppu;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [7:0]  wb_dat_w;
  logic [7:0]  wb_dat_r;
  logic        wb_ack;
  logic [13:0] vram_a;
  logic [7:0]  vram_din;
  logic [7:0]  vram_dout;
  logic        vram_r;
  logic        vram_w;
  logic [`PPU_COLOR_W-1:0] color;
  logic        nmi;
  logic [8:0]  scanline;
  logic [8:0]  cycle;

  logic [7:0]  cmd_q[$];      // Command letters
  int          arg_q[$];      // Register, address or VRAM constant
  int          exp_q[$];      // Data or expected value
  logic [21:0] write_q[$];    // Seen VRAM writes, {address, data}
  int          frame_cmds;    // Count of P and B commands that may take up to two frames
  longint      limit_cycles;
  int          errors;
  int          checks;
  logic        const_mode;    // VRAM returns one byte everywhere
  logic [7:0]  const_data;

  ppu_top ppu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Synchronous VRAM model returns the byte for an address one cycle later
  always @(posedge clk) begin
    vram_din <= const_mode ? const_data : (vram_a[7:0] ^ 8'h5A);
  end

  always @(negedge clk) begin
    if (!reset && vram_w) write_q.push_back({vram_a, vram_dout});
  end

  task automatic load_stimulus();
    int         fd;
    int         code;
    int         ch;
    int         a;
    int         b;
    logic [7:0] c;
    fd = $fopen("bench/ppu_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the stimulus file bench/ppu_stimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", c);
      if (code != 1) break;
      if (c == "#") begin  // Skip the rest of a comment line
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) ch = $fgetc(fd);
      end else begin
        code = $fscanf(fd, "%h %h", a, b);
        if (code != 2) begin
          errors++;
          $display("Stimulus line for command %c has missing operands", c);
          break;
        end
        cmd_q.push_back(c);
        arg_q.push_back(a);
        exp_q.push_back(b);
        if (c == "P" || c == "B") frame_cmds++;
      end
    end
    $fclose(fd);
  endtask

  // One Wishbone classic access with the data captured in the ack cycle
  task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk);
    while (!wb_ack && waited < 16) begin
      waited++;
      @(negedge clk);
    end
    if (!wb_ack) begin
      errors++;
      $display("Bus access to register %0d got no ack", adr);
    end else begin
      // Only a read of the data register starts a VRAM read
      assert (vram_r == (!we && adr == 3'd7)) else begin
        errors++;
        $display("FAILED at %0d ns: vram_r %0b in the ack cycle of register %0d",
                 $time, vram_r, adr);
      end
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  // Colour check over lines 8 to 200 and cycles 16 to 239 of the next full frame
  task automatic check_window(input logic [7:0] vram_const, input logic [5:0] expected);
    logic window_ok;
    int   samples;
    @(negedge clk);
    const_mode = 1'b1;
    const_data = vram_const;
    while (scanline != 9'(`PPU_PRE_LINE)) @(negedge clk);
    while (scanline != 9'd8) @(negedge clk);
    window_ok = 1'b1;
    samples   = 0;
    checks++;
    while (scanline <= 9'd200) begin
      if (cycle >= 9'd16 && cycle <= 9'd239) begin
        samples++;
        if (window_ok) begin
          assert (color == expected) else begin
            errors++;
            window_ok = 1'b0;  // One report per window
            $display("FAILED at %0d ns: colour %02h at line %0d cycle %0d, expected %02h",
                     $time, color, scanline, cycle, expected);
          end
        end
      end
      @(negedge clk);
    end
    // 193 lines of 224 pixels
    assert (samples == 193 * 224) else begin
      errors++;
      $display("FAILED at %0d ns: colour window covered %0d pixels, expected %0d",
               $time, samples, 193 * 224);
    end
  endtask

  task automatic run_command(input logic [7:0] c, input int a, input int b);
    logic [7:0]  rdata;
    logic [21:0] got;
    case (c)
      "W": bus_cycle(1'b1, a[2:0], b[7:0], rdata);
      "R": begin
        bus_cycle(1'b0, a[2:0], 8'h00, rdata);
        if (b <= 'hFF) begin  // Larger values mark a read that is not checked
          checks++;
          assert (rdata == b[7:0]) else begin
            errors++;
            $display("FAILED at %0d ns: register %0d read %02h, expected %02h",
                     $time, a, rdata, b[7:0]);
          end
        end
      end
      "V": begin
        checks++;
        if (write_q.size() == 0) begin
          errors++;
          $display("No VRAM write seen, expected one at %04h", a);
        end else begin
          got = write_q.pop_front();
          assert (got == {a[13:0], b[7:0]}) else begin
            errors++;
            $display("FAILED at %0d ns: VRAM write %04h=%02h, expected %04h=%02h",
                     $time, got[21:8], got[7:0], a[13:0], b[7:0]);
          end
        end
      end
      "P": check_window(a[7:0], b[5:0]);
      "B": begin
        @(negedge clk);
        while (scanline != 9'(`PPU_VBLANK_LINE - 1)) @(negedge clk);
        while (scanline != 9'(`PPU_VBLANK_LINE)) @(negedge clk);
        checks++;
        assert (nmi == b[0]) else begin
          errors++;
          $display("FAILED at %0d ns: nmi %0b at vblank start, expected %0b", $time, nmi, b[0]);
        end
      end
      default: begin
        errors++;
        $display("Unknown stimulus command %c", c);
      end
    endcase
  endtask

  initial begin
    reset      <= 1'b1;
    wb_cyc     <= 1'b0;
    wb_stb     <= 1'b0;
    wb_we      <= 1'b0;
    wb_adr     <= 3'd0;
    wb_dat_w   <= 8'h00;
    vram_din   <= 8'h00;
    const_mode = 1'b0;
    const_data = 8'h00;
    errors     = 0;
    checks     = 0;
    frame_cmds = 0;
    load_stimulus();
    // Three frames per frame-level command, a few cycles per bus command, plus margin
    limit_cycles = longint'(frame_cmds) * 3 * `PPU_LINE_CYCLES * `PPU_FRAME_LINES
                 + longint'(cmd_q.size()) * 40 + 2000;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (cmd_q[i]) run_command(cmd_q[i], arg_q[i], exp_q[i]);
    assert (write_q.size() == 0) else begin
      errors++;
      $display("%0d VRAM writes were never checked", write_q.size());
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * 8);
    $display("Watchdog expired, the run took longer than the stimulus allows");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* rtl/ppu_top.sv */
// Picture processor top level, background path only
// Raster timer, scroll registers, background fetch, palette and CPU registers
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [2:0]              wb_adr,
  input  logic [7:0]              wb_dat_w,
  output logic [7:0]              wb_dat_r,
  output logic                    wb_ack,
  output logic [13:0]             vram_a,
  input  logic [7:0]              vram_din,
  output logic [7:0]              vram_dout,
  output logic                    vram_r,
  output logic                    vram_w,
  output logic [`PPU_COLOR_W-1:0] color,
  output logic                    nmi,
  output logic [8:0]              scanline,
  output logic [8:0]              cycle
);

  ppu_pkg::raster_t      raster;
  ppu_pkg::cpu_access_t  access;
  ppu_pkg::scroll_addr_t vaddr;
  ppu_pkg::ppu_ctrl_t    ctrl;
  ppu_pkg::ppu_mask_t    mask;
  logic                  rendering;
  logic [2:0]            fine_x;
  logic [3:0]            pixel;
  logic [4:0]            pal_addr;
  logic                  pal_write;

  // Pixel while drawing, else the data port when it points at the palette
  assign pal_addr = rendering              ? {1'b0, pixel} :
                    (vaddr[13:8] == 6'h3F) ? vaddr[4:0]    : 5'd0;

  ppu_raster_timer raster_timer_i (
    .clk       (clk),
    .reset     (reset),
    .bg_enable (mask.bg_enable),
    .raster    (raster),
    .rendering (rendering)
  );

  ppu_scroll_regs scroll_regs_i (
    .clk       (clk),
    .reset     (reset),
    .raster    (raster),
    .rendering (rendering),
    .access    (access),
    .vaddr     (vaddr),
    .fine_x    (fine_x)
  );

  ppu_bg_fetch bg_fetch_i (
    .clk       (clk),
    .reset     (reset),
    .raster    (raster),
    .rendering (rendering),
    .vaddr     (vaddr),
    .fine_x    (fine_x),
    .bg_patt   (ctrl.bg_patt),
    .bg_clip   (mask.bg_clip),
    .bg_enable (mask.bg_enable),
    .vram_din  (vram_din),
    .vram_a    (vram_a),
    .pixel     (pixel)
  );

  ppu_palette_ram palette_ram_i (
    .clk       (clk),
    .addr      (pal_addr),
    .din       (vram_dout[`PPU_COLOR_W-1:0]),
    .write     (pal_write),
    .grayscale (mask.grayscale),
    .color     (color)
  );

  ppu_bus_regs bus_regs_i (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .raster    (raster),
    .rendering (rendering),
    .vaddr     (vaddr),
    .color     (color),
    .vram_din  (vram_din),
    .ctrl      (ctrl),
    .mask      (mask),
    .access    (access),
    .pal_write (pal_write),
    .vram_r    (vram_r),
    .vram_w    (vram_w),
    .vram_dout (vram_dout),
    .nmi       (nmi)
  );

  assign scanline = raster.scanline;
  assign cycle    = raster.cycle;

endmodule

/* rtl/ppu_bus_regs.sv */
// CPU register file
// Wishbone slave with control, mask, status, NMI and the VRAM data port
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_bus_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [2:0]              wb_adr,
  input  logic [7:0]              wb_dat_w,
  output logic [7:0]              wb_dat_r,
  output logic                    wb_ack,
  input  ppu_pkg::raster_t        raster,
  input  logic                    rendering,
  input  ppu_pkg::scroll_addr_t   vaddr,
  input  logic [`PPU_COLOR_W-1:0] color,
  input  logic [7:0]              vram_din,
  output ppu_pkg::ppu_ctrl_t      ctrl,
  output ppu_pkg::ppu_mask_t      mask,
  output ppu_pkg::cpu_access_t    access,
  output logic                    pal_write,
  output logic                    vram_r,
  output logic                    vram_w,
  output logic [7:0]              vram_dout,
  output logic                    nmi
);

  ppu_pkg::reg_addr_e reg_sel;
  logic               vbl_flag;     // Status bit 7
  logic               rd_pending;   // VRAM byte arrives one cycle after vram_r
  logic [7:0]         rd_buf;
  logic               is_pal;
  logic               data_wr;
  logic               status_rd;

  assign reg_sel   = ppu_pkg::reg_addr_e'(wb_adr);
  assign is_pal    = (vaddr[13:8] == 6'h3F);
  assign data_wr   = wb_ack && wb_we && (reg_sel == ppu_pkg::reg_data);
  assign status_rd = wb_ack && !wb_we && (reg_sel == ppu_pkg::reg_status);

  // Broadcast only in the ack cycle
  always_comb begin
    access = '0;
    if (wb_ack) begin
      access.addr     = reg_sel;
      access.data     = wb_dat_w;
      access.is_write = wb_we;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack     <= 1'b0;
      ctrl       <= '0;
      mask       <= '0;
      vbl_flag   <= 1'b1;
      rd_pending <= 1'b0;
    end else begin
      wb_ack     <= wb_cyc && wb_stb && !wb_ack;  // One wait state, one-cycle ack
      rd_pending <= vram_r;
      if (wb_ack && wb_we && reg_sel == ppu_pkg::reg_ctrl) begin
        ctrl.nmi_enable <= wb_dat_w[7];
        ctrl.bg_patt    <= wb_dat_w[4];
        ctrl.incr32     <= wb_dat_w[2];
        ctrl.nt_sel     <= wb_dat_w[1:0];
      end
      if (wb_ack && wb_we && reg_sel == ppu_pkg::reg_mask) begin
        mask.bg_enable <= wb_dat_w[3];
        mask.bg_clip   <= wb_dat_w[1];
        mask.grayscale <= wb_dat_w[0];
      end
      if (raster.entering_vblank) vbl_flag <= 1'b1;
      if (raster.exiting_vblank || status_rd) vbl_flag <= 1'b0;  // Read wins
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) rd_buf <= vram_din;
  end

  assign nmi       = vbl_flag && ctrl.nmi_enable;
  assign vram_w    = data_wr && !is_pal && !rendering;
  assign vram_r    = wb_ack && !wb_we && (reg_sel == ppu_pkg::reg_data);
  assign vram_dout = wb_dat_w;
  assign pal_write = data_wr && is_pal && !rendering;

  always_comb begin
    case (reg_sel)
      ppu_pkg::reg_status: wb_dat_r = {vbl_flag, 7'b0000000};  // No sprite flags
      ppu_pkg::reg_data:   wb_dat_r = is_pal ? {2'b00, color} : rd_buf;
      default:             wb_dat_r = 8'h00;
    endcase
  end

endmodule

/* rtl/ppu_palette_ram.sv */
// Palette RAM
// 32 colour entries, backdrop mirroring and grayscale masking
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_palette_ram (
  input  logic                    clk,
  input  logic [4:0]              addr,
  input  logic [`PPU_COLOR_W-1:0] din,
  input  logic                    write,
  input  logic                    grayscale,
  output logic [`PPU_COLOR_W-1:0] color
);

  logic [`PPU_COLOR_W-1:0] mem [`PPU_PAL_DEPTH];
  logic [4:0]              eff_addr;
  logic [`PPU_COLOR_W-1:0] raw;
  logic                    wr_ok;

  // Every entry with low bits 00 reads the backdrop
  assign eff_addr = (addr[1:0] == 2'b00) ? 5'd0 : addr;
  // Entries 4, 8, 12 and mirrors ignore writes, 0 and 16 land on the backdrop
  assign wr_ok    = (addr[1:0] != 2'b00) || (addr[3:2] == 2'b00);

  always_ff @(posedge clk) begin
    if (write && wr_ok) mem[eff_addr] <= din;
  end

  assign raw   = mem[eff_addr];
  assign color = grayscale ? {raw[5:4], 4'b0000} : raw;  // Keep luma only

endmodule

/* rtl/ppu_bg_fetch.sv */
// Background fetch
// Name, attribute and pattern fetches every 8 cycles into the pixel shift pipes
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_bg_fetch (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::raster_t      raster,
  input  logic                  rendering,
  input  ppu_pkg::scroll_addr_t vaddr,
  input  logic [2:0]            fine_x,
  input  logic                  bg_patt,
  input  logic                  bg_clip,
  input  logic                  bg_enable,
  input  logic [7:0]            vram_din,
  output logic [13:0]           vram_a,
  output logic [3:0]            pixel
);

  logic [7:0]  name_q;      // Tile index
  logic [1:0]  attr_q;      // Palette bits for the tile
  logic [7:0]  patt_lo_q;   // Plane 0, plane 1 comes straight off the bus
  logic [15:0] pat_lo;
  logic [15:0] pat_hi;
  logic [8:0]  at_lo;
  logic [8:0]  at_hi;
  logic [2:0]  phase;
  logic        shift_en;
  logic        load;
  logic [3:0]  pat_idx;
  logic [3:0]  at_idx;
  logic        show_lo;

  assign phase    = raster.cycle[2:0];
  assign shift_en = rendering && (raster.cycle < 9'(`PPU_FETCH_END));
  assign load     = shift_en && (phase == 3'd7);

  always_comb begin
    if (!rendering) begin
      vram_a = vaddr[13:0];  // CPU data port
    end else begin
      case (phase[2:1])
        2'd0: vram_a = {2'b10, vaddr[11:0]};
        2'd1: vram_a = {2'b10, vaddr.nt_y, vaddr.nt_x, 4'b1111,
                        vaddr.coarse_y[4:2], vaddr.coarse_x[4:2]};
        default: vram_a = {1'b0, bg_patt, name_q, phase[1], vaddr.fine_y};
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      name_q    <= '0;
      attr_q    <= '0;
      patt_lo_q <= '0;
      pat_lo    <= '0;
      pat_hi    <= '0;
      at_lo     <= '0;
      at_hi     <= '0;
    end else if (rendering) begin
      case (phase)
        3'd1: name_q <= vram_din;
        // Quadrant from bit 1 of coarse X and coarse Y
        3'd3: attr_q <= vram_din[{vaddr.coarse_y[1], vaddr.coarse_x[1], 1'b0} +: 2];
        3'd5: patt_lo_q <= vram_din;
        default: ;
      endcase
      if (shift_en) begin
        // Pipes shift toward the MSB, new tile enters at the bottom
        pat_lo <= load ? {pat_lo[14:7], patt_lo_q} : {pat_lo[14:0], 1'b0};
        pat_hi <= load ? {pat_hi[14:7], vram_din} : {pat_hi[14:0], 1'b0};
        at_lo  <= {at_lo[7:0], load ? attr_q[0] : at_lo[0]};
        at_hi  <= {at_hi[7:0], load ? attr_q[1] : at_hi[0]};
      end
    end
  end

  assign pat_idx = 4'd15 - {1'b0, fine_x};
  assign at_idx  = 4'd8 - {1'b0, fine_x};
  // Left 8 pixels blank unless clipping is off
  assign show_lo = bg_enable && (bg_clip || raster.cycle[7:3] != 5'd0);
  assign pixel   = {at_hi[at_idx], at_lo[at_idx],
                    show_lo ? {pat_hi[pat_idx], pat_lo[pat_idx]} : 2'b00};

endmodule

/* rtl/ppu_scroll_regs.sv */
// Scroll registers
// Temporary and current VRAM address, fine X and the shared write latch
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_scroll_regs (
  input  logic                  clk,
  input  logic                  reset,
  input  ppu_pkg::raster_t      raster,
  input  logic                  rendering,
  input  ppu_pkg::cpu_access_t  access,
  output ppu_pkg::scroll_addr_t vaddr,
  output logic [2:0]            fine_x
);

  ppu_pkg::scroll_addr_t    v;       // Current address
  ppu_pkg::scroll_addr_t    t;       // Temporary address
  logic                     incr32;
  logic                     latch;   // 0 = first write, 1 = second write
  logic [`PPU_VADDR_W-1:0]  step;
  logic [8:0]               cyc;
  logic                     coarse_x_tick;
  logic                     data_access;

  assign cyc  = raster.cycle;
  assign step = incr32 ? `PPU_VADDR_W'(32) : `PPU_VADDR_W'(1);
  // Right after each attribute fetch, in the visible and prefetch windows
  assign coarse_x_tick = (cyc[2:0] == 3'd3) &&
                         (cyc < 9'(`PPU_VISIBLE_W) ||
                          (cyc >= 9'd320 && cyc < 9'(`PPU_FETCH_END)));
  assign data_access = (access.addr == ppu_pkg::reg_data) && !rendering;

  always_ff @(posedge clk) begin
    if (reset) begin
      v      <= '0;
      t      <= '0;
      fine_x <= '0;
      incr32 <= 1'b0;
      latch  <= 1'b0;
    end else begin
      if (rendering) begin
        if (coarse_x_tick) begin
          v.coarse_x <= v.coarse_x + 5'd1;
          if (v.coarse_x == 5'd31) v.nt_x <= !v.nt_x;  // Next name table across
        end
        if (cyc == 9'd251) begin
          v.fine_y <= v.fine_y + 3'd1;
          if (v.fine_y == 3'd7) begin
            if (v.coarse_y == 5'd29) begin  // Last tile row, flip vertical table
              v.coarse_y <= 5'd0;
              v.nt_y     <= !v.nt_y;
            end else begin
              v.coarse_y <= v.coarse_y + 5'd1;
            end
          end
        end
        if (cyc == 9'(`PPU_VISIBLE_W)) begin  // Horizontal reload
          v.nt_x     <= t.nt_x;
          v.coarse_x <= t.coarse_x;
        end
        if (cyc == 9'd304 && raster.pre_render) v <= t;
      end

      // CPU side, later assignments win over the rendering updates
      if (access.is_write) begin
        case (access.addr)
          ppu_pkg::reg_ctrl: begin
            t.nt_x <= access.data[0];
            t.nt_y <= access.data[1];
            incr32 <= access.data[2];
          end
          ppu_pkg::reg_scroll: begin
            if (!latch) begin
              t.coarse_x <= access.data[7:3];
              fine_x     <= access.data[2:0];
            end else begin
              t.coarse_y <= access.data[7:3];
              t.fine_y   <= access.data[2:0];
            end
            latch <= !latch;
          end
          ppu_pkg::reg_addr: begin
            if (!latch) begin
              t[13:8] <= access.data[5:0];  // High byte, bit 14 forced low
              t[14]   <= 1'b0;
            end else begin
              t[7:0] <= access.data;
              v      <= ppu_pkg::scroll_addr_t'({t[14:8], access.data});
            end
            latch <= !latch;
          end
          default: ;
        endcase
      end else if (access.addr == ppu_pkg::reg_status) begin
        latch <= 1'b0;
      end
      if (data_access) v <= ppu_pkg::scroll_addr_t'(v + step);
    end
  end

  assign vaddr = v;

endmodule

/* rtl/ppu_raster_timer.sv */
// Raster timer
// Cycle and scanline counters, vblank window and rendering flag
`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_raster_timer (
  input  logic              clk,
  input  logic              reset,
  input  logic              bg_enable,
  output ppu_pkg::raster_t  raster,
  output logic              rendering
);

  logic [8:0] cycle;
  logic [8:0] scanline;
  logic       in_vblank;
  logic       odd_frame;    // Toggles once per frame at vblank exit
  logic       pre_render;
  logic [8:0] last_cycle;
  logic       end_of_line;
  logic       entering;
  logic       exiting;

  assign pre_render = (scanline == 9'(`PPU_PRE_LINE));
  // Line 240 is idle even with the background on
  assign rendering  = bg_enable && !in_vblank && (scanline != 9'(`PPU_VBLANK_LINE - 1));

  // Pre-render line drops its last cycle on every second frame
  assign last_cycle  = (pre_render && odd_frame && rendering) ? 9'(`PPU_LINE_CYCLES - 2)
                                                               : 9'(`PPU_LINE_CYCLES - 1);
  assign end_of_line = (cycle == last_cycle);
  assign entering    = end_of_line && (scanline == 9'(`PPU_VBLANK_LINE - 1));
  assign exiting     = end_of_line && (scanline == 9'(`PPU_PRE_LINE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= '0;
      scanline  <= '0;
      in_vblank <= 1'b1;
      odd_frame <= 1'b0;
    end else begin
      cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
      if (end_of_line) begin
        // Wrap from the pre-render line back to line 0
        scanline <= (scanline == 9'(`PPU_FRAME_LINES - 1)) ? 9'd0 : scanline + 9'd1;
      end
      if (entering) begin
        in_vblank <= 1'b1;
      end else if (exiting) begin
        in_vblank <= 1'b0;
      end
      if (exiting) odd_frame <= !odd_frame;
    end
  end

  assign raster.scanline        = scanline;
  assign raster.cycle           = cycle;
  assign raster.in_vblank       = in_vblank;
  assign raster.pre_render      = pre_render;
  assign raster.entering_vblank = entering;
  assign raster.exiting_vblank  = exiting;

endmodule

/* rtl/ppu_pkg.sv */
// Picture processor types
// Register names and the packed bundles passed between blocks
package ppu_pkg;

  // CPU register index, as seen on wb_adr
  typedef enum logic [2:0] {
    reg_ctrl     = 3'd0,
    reg_mask     = 3'd1,
    reg_status   = 3'd2,
    reg_oam_addr = 3'd3,
    reg_oam_data = 3'd4,
    reg_scroll   = 3'd5,
    reg_addr     = 3'd6,
    reg_data     = 3'd7
  } reg_addr_e;

  // Scroll / VRAM address layout, yyy NN YYYYY XXXXX
  typedef struct packed {
    logic [2:0] fine_y;
    logic       nt_y;
    logic       nt_x;
    logic [4:0] coarse_y;
    logic [4:0] coarse_x;
  } scroll_addr_t;

  typedef struct packed {
    logic       nmi_enable;  // NMI at vblank start
    logic       slave;
    logic       obj_size;
    logic       bg_patt;     // Background pattern table select
    logic       obj_patt;
    logic       incr32;      // Data port steps by 32
    logic [1:0] nt_sel;      // Base name table
  } ppu_ctrl_t;

  typedef struct packed {
    logic [2:0] intensity;
    logic       obj_enable;
    logic       bg_enable;
    logic       obj_clip;
    logic       bg_clip;     // 1 shows background in the left 8 pixels
    logic       grayscale;
  } ppu_mask_t;

  typedef struct packed {
    logic [8:0] scanline;
    logic [8:0] cycle;
    logic       in_vblank;
    logic       pre_render;
    logic       entering_vblank;  // Last cycle of line 240
    logic       exiting_vblank;   // Last cycle of line 260
  } raster_t;

  // One acknowledged CPU access; all zero reads as a harmless ctrl read
  typedef struct packed {
    reg_addr_e  addr;
    logic [7:0] data;
    logic       is_write;
  } cpu_access_t;

endpackage

/* rtl/ppu_settings.svh */
// Picture processor settings
// Raster geometry, address and colour widths shared by the RTL
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// Raster geometry, one clk per pixel
`define PPU_LINE_CYCLES 341   // Cycles per line, counted in 9 bits
`define PPU_FRAME_LINES 262   // Lines per frame
`define PPU_VBLANK_LINE 241   // First vblank line
`define PPU_PRE_LINE    261   // Pre-render line
`define PPU_VISIBLE_W   256   // Visible pixels per line
`define PPU_FETCH_END   336   // End of the prefetch window for the next line

// Widths and depths
`define PPU_VADDR_W     15    // Scroll / VRAM address register
`define PPU_PAL_DEPTH   32    // Palette entries
`define PPU_COLOR_W     6     // Colour index out of the palette

`endif
